/* src/sec_cache_pkg.sv */
// Shared widths, address constants, field helpers and controller state type
package sec_cache_pkg;

	localparam int ADDR_W    = 32;
	localparam int WORD_W    = 32;
	localparam int LINE_W    = 128;
	localparam int NUM_LINES = 16;

	// Byte offset bits inside one word
	localparam int BYTE_OFS_W = $clog2(WORD_W / 8);

	typedef logic [ADDR_W-1:0]                  addr_t;
	typedef logic [WORD_W-1:0]                  word_t;
	typedef logic [LINE_W-1:0]                  line_t;
	typedef logic [$clog2(NUM_LINES)-1:0]       index_t;
	typedef logic [$clog2(LINE_W / WORD_W)-1:0] offset_t;
	typedef logic [ADDR_W-$bits(index_t)-$bits(offset_t)-BYTE_OFS_W-1:0] tag_t;
	typedef logic                               domain_t;

	localparam addr_t   DIRECT_ADDR    = 32'h0000_0000;
	localparam addr_t   CTRL_ADDR      = 32'h0000_0004;
	localparam addr_t   RESET_BOUNDARY = 32'h0000_C000;
	localparam domain_t DOMAIN_TRUSTED = 1'b1;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DECODE,
		ST_CTRL_WRITE,
		ST_EMPTY_RESP,
		ST_LOOKUP,
		ST_MEM_READ,
		ST_MEM_WRITE,
		ST_RESPOND
	} ctrl_state_t;

	// ------------------------------------------------------------------
	// Address split into tag, index, word offset and byte offset
	// ------------------------------------------------------------------

	function automatic offset_t addr_offset(addr_t addr);
		return addr[BYTE_OFS_W +: $bits(offset_t)];
	endfunction

	function automatic index_t addr_index(addr_t addr);
		return addr[BYTE_OFS_W + $bits(offset_t) +: $bits(index_t)];
	endfunction

	function automatic tag_t addr_tag(addr_t addr);
		return addr[ADDR_W-1 -: $bits(tag_t)];
	endfunction

	function automatic word_t line_word(line_t line, offset_t ofs);
		return line[ofs*WORD_W +: WORD_W];
	endfunction

endpackage

/* src/sec_cache_if.sv */
// Cache array interface and memory command interface, each with two modports

// Controller to tag/data arrays
interface cache_if import sec_cache_pkg::*; ();

	addr_t lookup_addr;
	logic  fill;
	line_t fill_line;
	logic  wr_en;
	word_t wr_data;
	logic  hit;
	word_t rd_word;

	modport ctrl (
		output lookup_addr, fill, fill_line, wr_en, wr_data,
		input  hit, rd_word
	);

	modport array (
		input  lookup_addr, fill, fill_line, wr_en, wr_data,
		output hit, rd_word
	);

endinterface

// Controller to memory port sequencer
interface mem_cmd_if import sec_cache_pkg::*; ();

	logic    cmd_val;
	logic    cmd_write;
	addr_t   cmd_addr;
	word_t   cmd_data;
	domain_t cmd_domain;
	logic    cmd_rdy;
	logic    done;
	line_t   rd_line;
	word_t   rd_word;

	modport ctrl (
		output cmd_val, cmd_write, cmd_addr, cmd_data, cmd_domain,
		input  cmd_rdy, done, rd_line, rd_word
	);

	modport port (
		input  cmd_val, cmd_write, cmd_addr, cmd_data, cmd_domain,
		output cmd_rdy, done, rd_line, rd_word
	);

endinterface

/* src/access_ctrl.sv */
// Request FSM, boundary register and cacheability decision
module access_ctrl import sec_cache_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    req_val,
	input  logic    req_write,
	input  addr_t   req_addr,
	input  word_t   req_data,
	input  domain_t req_domain,
	output logic    req_rdy,
	output logic    resp_val,
	output word_t   resp_data,
	output domain_t resp_domain,
	input  logic    resp_rdy,
	cache_if.ctrl   cache,
	mem_cmd_if.ctrl mem
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	// Accepted request
	addr_t   addr_q;
	word_t   data_q;
	logic    write_q;
	domain_t domain_q;

	// Addresses below this go through the cache
	addr_t boundary;

	// Command already handed to the memory port
	logic cmd_sent;

	logic is_direct;
	logic is_ctrl;
	logic use_cache;

	assign is_direct = (addr_q == DIRECT_ADDR);
	assign is_ctrl   = (addr_q == CTRL_ADDR);
	assign use_cache = !is_direct && !is_ctrl && (addr_q < boundary);

	// ------------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (req_val)
					state_next = ST_DECODE;
			ST_DECODE: begin
				if (is_ctrl)
					state_next = (domain_q == DOMAIN_TRUSTED) ? ST_CTRL_WRITE : ST_EMPTY_RESP;
				else if (use_cache)
					state_next = ST_LOOKUP;
				else if (write_q)
					state_next = ST_MEM_WRITE;
				else
					state_next = ST_MEM_READ;
			end
			ST_CTRL_WRITE,
			ST_EMPTY_RESP:
				state_next = ST_RESPOND;
			ST_LOOKUP: begin
				// Writes always go through to memory
				if (write_q)
					state_next = ST_MEM_WRITE;
				else if (cache.hit)
					state_next = ST_RESPOND;
				else
					state_next = ST_MEM_READ;
			end
			ST_MEM_READ,
			ST_MEM_WRITE:
				if (mem.done)
					state_next = ST_RESPOND;
			ST_RESPOND:
				if (resp_rdy)
					state_next = ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	// ------------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= ST_IDLE;
			boundary <= RESET_BOUNDARY;
			cmd_sent <= 1'b0;
		end else begin
			state <= state_next;
			if (state == ST_CTRL_WRITE && write_q)
				boundary <= data_q;
			if (mem.cmd_val && mem.cmd_rdy)
				cmd_sent <= 1'b1;
			else if (mem.done)
				cmd_sent <= 1'b0;
		end
	end

	// Request capture and response data
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req_val) begin
			addr_q   <= req_addr;
			data_q   <= req_data;
			write_q  <= req_write;
			domain_q <= req_domain;
		end
		case (state)
			// A trusted read of the control port returns the boundary
			ST_CTRL_WRITE: resp_data <= write_q ? '0 : boundary;
			ST_EMPTY_RESP: resp_data <= '0;
			ST_LOOKUP:
				if (!write_q && cache.hit)
					resp_data <= cache.rd_word;
			ST_MEM_READ:
				if (mem.done)
					resp_data <= mem.rd_word;
			ST_MEM_WRITE:
				if (mem.done)
					resp_data <= '0;
			default: ;
		endcase
	end

	// ------------------------------------------------------------------
	// Outputs
	// ------------------------------------------------------------------

	assign req_rdy     = (state == ST_IDLE);
	assign resp_val    = (state == ST_RESPOND);
	assign resp_domain = domain_q;

	assign cache.lookup_addr = addr_q;
	assign cache.fill        = (state == ST_MEM_READ) && mem.done && use_cache;
	assign cache.fill_line   = mem.rd_line;
	assign cache.wr_en       = (state == ST_LOOKUP) && write_q;
	assign cache.wr_data     = data_q;

	assign mem.cmd_val    = (state == ST_MEM_READ || state == ST_MEM_WRITE) && !cmd_sent;
	assign mem.cmd_write  = (state == ST_MEM_WRITE);
	assign mem.cmd_addr   = addr_q;
	assign mem.cmd_data   = data_q;
	assign mem.cmd_domain = domain_q;

endmodule

/* src/line_cache.sv */
// Direct-mapped valid, tag and line arrays with hit detection, fill and word write
module line_cache import sec_cache_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	cache_if.array cache
);

	logic [NUM_LINES-1:0] valid;
	tag_t                 tags  [NUM_LINES];
	line_t                lines [NUM_LINES];

	index_t  idx;
	tag_t    tag;
	offset_t ofs;

	assign idx = addr_index(cache.lookup_addr);
	assign tag = addr_tag(cache.lookup_addr);
	assign ofs = addr_offset(cache.lookup_addr);

	// Lookup is purely combinational
	assign cache.hit     = valid[idx] && (tags[idx] == tag);
	assign cache.rd_word = line_word(lines[idx], ofs);

	always_ff @(posedge clk) begin
		if (reset)
			valid <= '0;
		else if (cache.fill)
			valid[idx] <= 1'b1;
	end

	// ------------------------------------------------------------------
	// Fill loads a whole line and a write hit patches one word
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (cache.fill) begin
			tags[idx]  <= tag;
			lines[idx] <= cache.fill_line;
		end else if (cache.wr_en && cache.hit) begin
			lines[idx][ofs*WORD_W +: WORD_W] <= cache.wr_data;
		end
	end

endmodule

/* src/mem_port.sv */
// Memory request sequencer with line capture and word select
module mem_port import sec_cache_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	mem_cmd_if.port  mem,
	output logic     memreq_val,
	output logic     memreq_write,
	output addr_t    memreq_addr,
	output word_t    memreq_data,
	output domain_t  memreq_domain,
	input  logic     memreq_rdy,
	input  logic     memresp_val,
	input  line_t    memresp_data
);

	typedef enum logic [1:0] {MP_IDLE, MP_REQ, MP_WAIT} port_state_t;

	port_state_t state;

	addr_t   addr_q;
	word_t   data_q;
	logic    write_q;
	domain_t domain_q;
	line_t   line_q;
	logic    read_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= MP_IDLE;
			read_done <= 1'b0;
		end else begin
			read_done <= (state == MP_WAIT) && memresp_val;
			case (state)
				MP_IDLE:
					if (mem.cmd_val)
						state <= MP_REQ;
				MP_REQ:
					// Writes finish on acceptance
					if (memreq_rdy)
						state <= write_q ? MP_IDLE : MP_WAIT;
				MP_WAIT:
					if (memresp_val)
						state <= MP_IDLE;
				default:
					state <= MP_IDLE;
			endcase
		end
	end

	// Command latch and returned line
	always_ff @(posedge clk) begin
		if (state == MP_IDLE && mem.cmd_val) begin
			addr_q   <= mem.cmd_addr;
			data_q   <= mem.cmd_data;
			write_q  <= mem.cmd_write;
			domain_q <= mem.cmd_domain;
		end
		if (state == MP_WAIT && memresp_val)
			line_q <= memresp_data;
	end

	assign mem.cmd_rdy = (state == MP_IDLE);
	assign mem.done    = ((state == MP_REQ) && memreq_rdy && write_q) || read_done;
	assign mem.rd_line = line_q;
	assign mem.rd_word = line_word(line_q, addr_offset(addr_q));

	assign memreq_val    = (state == MP_REQ);
	assign memreq_write  = write_q;
	assign memreq_addr   = addr_q;
	assign memreq_data   = data_q;
	assign memreq_domain = domain_q;

endmodule

/* src/sec_cache_top.sv */
// Secure cache front end top level with controller, line cache and memory port instances
module sec_cache_top import sec_cache_pkg::*; (
	input  logic    clk,
	input  logic    reset,

	// Processor request
	input  logic    req_val,
	input  logic    req_write,
	input  addr_t   req_addr,
	input  word_t   req_data,
	input  domain_t req_domain,
	output logic    req_rdy,

	// Processor response
	output logic    resp_val,
	output word_t   resp_data,
	output domain_t resp_domain,
	input  logic    resp_rdy,

	// Memory request
	output logic    memreq_val,
	output logic    memreq_write,
	output addr_t   memreq_addr,
	output word_t   memreq_data,
	output domain_t memreq_domain,
	input  logic    memreq_rdy,

	// Memory response which is always accepted
	input  logic    memresp_val,
	input  line_t   memresp_data
);

	cache_if   cache_bus ();
	mem_cmd_if cmd_bus ();

	access_ctrl u_access_ctrl (
		.clk         (clk),
		.reset       (reset),
		.req_val     (req_val),
		.req_write   (req_write),
		.req_addr    (req_addr),
		.req_data    (req_data),
		.req_domain  (req_domain),
		.req_rdy     (req_rdy),
		.resp_val    (resp_val),
		.resp_data   (resp_data),
		.resp_domain (resp_domain),
		.resp_rdy    (resp_rdy),
		.cache       (cache_bus.ctrl),
		.mem         (cmd_bus.ctrl)
	);

	line_cache u_line_cache (
		.clk   (clk),
		.reset (reset),
		.cache (cache_bus.array)
	);

	mem_port u_mem_port (
		.clk           (clk),
		.reset         (reset),
		.mem           (cmd_bus.port),
		.memreq_val    (memreq_val),
		.memreq_write  (memreq_write),
		.memreq_addr   (memreq_addr),
		.memreq_data   (memreq_data),
		.memreq_domain (memreq_domain),
		.memreq_rdy    (memreq_rdy),
		.memresp_val   (memresp_val),
		.memresp_data  (memresp_data)
	);

endmodule

/* bench/mem_model.sv */
// Line-wide memory model with random back-pressure, read counter and word peek port
module mem_model import sec_cache_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  memreq_val,
	input  logic  memreq_write,
	input  addr_t memreq_addr,
	input  word_t memreq_data,
	output logic  memreq_rdy,
	output logic  memresp_val,
	output line_t memresp_data,
	output int    read_count,
	input  addr_t peek_addr,
	output word_t peek_data
);

	integer seed = 32'h4335;

	// Only written words are stored and the rest follow the fill pattern
	word_t store [addr_t];
	addr_t line_addr;
	int    resp_delay;

	function automatic word_t word_at(addr_t a);
		addr_t w;
		w = {a[ADDR_W-1:2], 2'b00};
		if (store.exists(w))
			return store[w];
		return w ^ 32'h5A5A_0000;
	endfunction

	always @(posedge clk) begin
		memresp_val <= 1'b0;
		memreq_rdy  <= ($random(seed) % 4) != 0;
		peek_data   <= word_at(peek_addr);
		if (reset) begin
			read_count <= 0;
			resp_delay <= 0;
		end else if (memreq_val && memreq_rdy) begin
			if (memreq_write) begin
				store[{memreq_addr[ADDR_W-1:2], 2'b00}] = memreq_data;
			end else begin
				read_count <= read_count + 1;
				line_addr  <= memreq_addr;
				resp_delay <= 1 + ($random(seed) & 3);
			end
		end else if (resp_delay == 1) begin
			// Whole line comes back in one beat
			memresp_val <= 1'b1;
			for (int i = 0; i < LINE_W / WORD_W; i++)
				memresp_data[i*WORD_W +: WORD_W] <=
					word_at({line_addr[ADDR_W-1:4], i[1:0], 2'b00});
			resp_delay <= 0;
		end else if (resp_delay > 1) begin
			resp_delay <= resp_delay - 1;
		end
	end

endmodule

/* bench/sec_cache_tb.sv */
// Testbench with clock, reset, stimulus table, response checks, watchdog and summary
module sec_cache_tb import sec_cache_pkg::*; ();

	typedef struct packed {
		logic    write;
		domain_t domain;
		addr_t   addr;
		word_t   data;
		word_t   expect_data;
		logic    mem_read;
	} row_t;

	logic    clk;
	logic    reset;
	logic    req_val;
	logic    req_write;
	addr_t   req_addr;
	word_t   req_data;
	domain_t req_domain;
	logic    req_rdy;
	logic    resp_val;
	word_t   resp_data;
	domain_t resp_domain;
	logic    resp_rdy;
	logic    memreq_val;
	logic    memreq_write;
	addr_t   memreq_addr;
	word_t   memreq_data;
	domain_t memreq_domain;
	logic    memreq_rdy;
	logic    memresp_val;
	line_t   memresp_data;
	int      mem_reads;
	addr_t   peek_addr;
	word_t   peek_data;

	row_t    rows[$];
	logic    table_ready = 1'b0;
	int      checks = 0;
	int      errors = 0;
	integer  seed = 32'h4335;
	domain_t active_domain = 1'b0;

	sec_cache_top UUT (.*);

	mem_model u_mem (
		.clk          (clk),
		.reset        (reset),
		.memreq_val   (memreq_val),
		.memreq_write (memreq_write),
		.memreq_addr  (memreq_addr),
		.memreq_data  (memreq_data),
		.memreq_rdy   (memreq_rdy),
		.memresp_val  (memresp_val),
		.memresp_data (memresp_data),
		.read_count   (mem_reads),
		.peek_addr    (peek_addr),
		.peek_data    (peek_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Untouched memory words read as address xor 5A5A0000
	function automatic word_t fresh_word(addr_t a);
		return a ^ 32'h5A5A_0000;
	endfunction

	function automatic void add_row(logic write, domain_t domain, addr_t addr,
			word_t data, word_t expect_data, logic mem_read);
		row_t r;
		r.write       = write;
		r.domain      = domain;
		r.addr        = addr;
		r.data        = data;
		r.expect_data = expect_data;
		r.mem_read    = mem_read;
		rows.push_back(r);
	endfunction

	task automatic compare_value(input string name, input word_t got, input word_t expected);
		checks++;
		if (got !== expected) begin
			$display("FAIL %s: got %h, expected %h", name, got, expected);
			errors++;
		end
	endtask

	// Every memory request carries the domain of the request in flight
	always @(negedge clk) begin
		if (memreq_val === 1'b1)
			compare_value("memreq_domain", 32'(memreq_domain), 32'(active_domain));
	end

	// ------------------------------------------------------------------
	// Stimulus table with the boundary starting at C000
	// ------------------------------------------------------------------

	task automatic build_table();
		// Uncached and direct reads always reach memory
		add_row(0, DOMAIN_TRUSTED, 32'h0000_D000, '0, fresh_word(32'h0000_D000), 1);
		add_row(0, DOMAIN_TRUSTED, 32'h0000_D000, '0, fresh_word(32'h0000_D000), 1);
		add_row(0, 1'b0, 32'h0000_0000, '0, fresh_word(32'h0000_0000), 1);
		// Miss followed by hits on the same line
		add_row(0, DOMAIN_TRUSTED, 32'h0000_0100, '0, fresh_word(32'h0000_0100), 1);
		add_row(0, DOMAIN_TRUSTED, 32'h0000_0100, '0, fresh_word(32'h0000_0100), 0);
		add_row(0, DOMAIN_TRUSTED, 32'h0000_0104, '0, fresh_word(32'h0000_0104), 0);
		// Write-through into a cached word
		add_row(1, DOMAIN_TRUSTED, 32'h0000_0104, 32'h1234_ABCD, '0, 0);
		add_row(0, DOMAIN_TRUSTED, 32'h0000_0104, '0, 32'h1234_ABCD, 0);
		// Untrusted control access is ignored so the line stays cacheable
		add_row(1, 1'b0, CTRL_ADDR, 32'h0000_0080, '0, 0);
		add_row(0, DOMAIN_TRUSTED, 32'h0000_0108, '0, fresh_word(32'h0000_0108), 0);
		add_row(0, 1'b0, CTRL_ADDR, '0, '0, 0);
		// Trusted boundary move makes 0100 uncached
		add_row(1, DOMAIN_TRUSTED, CTRL_ADDR, 32'h0000_0080, '0, 0);
		add_row(0, DOMAIN_TRUSTED, 32'h0000_0100, '0, fresh_word(32'h0000_0100), 1);
		add_row(0, DOMAIN_TRUSTED, 32'h0000_0100, '0, fresh_word(32'h0000_0100), 1);
		add_row(0, 1'b0, 32'h0000_0104, '0, 32'h1234_ABCD, 1);
		add_row(1, DOMAIN_TRUSTED, 32'h0000_0200, 32'hCAFE_0001, '0, 0);
		add_row(0, DOMAIN_TRUSTED, 32'h0000_0200, '0, 32'hCAFE_0001, 1);
	endtask

	// ------------------------------------------------------------------
	// One request and its response
	// ------------------------------------------------------------------

	task automatic run_row(input int n, input row_t r);
		int      reads_before;
		int      errors_before;
		int      stall;
		word_t   got_data;
		domain_t got_domain;
		reads_before  = mem_reads;
		errors_before = errors;
		active_domain = r.domain;
		@(posedge clk);
		req_val    <= 1'b1;
		req_write  <= r.write;
		req_addr   <= r.addr;
		req_data   <= r.data;
		req_domain <= r.domain;
		do @(negedge clk); while (!req_rdy);
		@(posedge clk);
		req_val <= 1'b0;
		do @(negedge clk); while (!resp_val);
		// Random response back-pressure
		stall = $random(seed) & 3;
		repeat (stall) begin
			@(negedge clk);
			if (!resp_val) begin
				$display("Response in row %0d dropped before it was accepted", n);
				errors++;
			end
		end
		got_data   = resp_data;
		got_domain = resp_domain;
		@(posedge clk);
		resp_rdy <= 1'b1;
		@(posedge clk);
		resp_rdy <= 1'b0;
		@(negedge clk);
		if (resp_val) begin
			$display("Response in row %0d repeated after it was accepted", n);
			errors++;
		end
		compare_value("resp_data", got_data, r.expect_data);
		compare_value("resp_domain", 32'(got_domain), 32'(r.domain));
		compare_value("mem_reads", 32'(mem_reads - reads_before), 32'(r.mem_read));
		$display("row %0d %0s addr %h domain %0d: %0s", n, r.write ? "write" : "read",
			r.addr, r.domain, (errors == errors_before) ? "ok" : "mismatch");
	endtask

	initial begin
		reset      = 1'b1;
		req_val    = 1'b0;
		req_write  = 1'b0;
		req_addr   = '0;
		req_data   = '0;
		req_domain = 1'b0;
		resp_rdy   = 1'b0;
		peek_addr  = '0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < rows.size(); i++)
			run_row(i, rows[i]);
		// Written word must have reached memory
		@(posedge clk);
		peek_addr <= 32'h0000_0104;
		repeat (2) @(posedge clk);
		@(negedge clk);
		compare_value("mem_word", peek_data, 32'h1234_ABCD);
		$display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Watchdog allowing 200 cycles per row
	initial begin
		wait (table_ready);
		repeat (rows.size() * 200) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", rows.size() * 200);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* sec_cache.f */
src/sec_cache_pkg.sv
src/sec_cache_if.sv
src/access_ctrl.sv
src/line_cache.sv
src/mem_port.sv
src/sec_cache_top.sv
bench/mem_model.sv
bench/sec_cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sec_cache_tb
FILELIST  ?= sec_cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test OK

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
